//--- test/debug_golden.txt
// Hex words for $readmemh: @00 snapshot bytes 0 to 15, @10 memory words 80 to 83
// @14 command count then (command byte, cpu_enable_o cycles) pairs, @40 reply length and bytes
@00
a5 01 02 03 10 20 30 40
de ad be ef 5a 3c 7e 81
@10
12345678
cafef00d
0badc0de
89abcdef
@14
5
70 1 // p
63 6 // c halts after 6 cycles
78 0 // x is not a command
63 3 // c halts after 3 cycles
70 1 // p
@40
8a
// Reply to p
a5 01 02 03 10 20 30 40
de ad be ef 5a 3c 7e 81
78 56 34 12 0d f0 fe ca
de c0 ad 0b ef cd ab 89
46 0a
// Reply to c
a5 01 02 03 10 20 30 40
de ad be ef 5a 3c 7e 81
78 56 34 12 0d f0 fe ca
de c0 ad 0b ef cd ab 89
46 0a
// Reply to x
45 0a
// Reply to c
a5 01 02 03 10 20 30 40
de ad be ef 5a 3c 7e 81
78 56 34 12 0d f0 fe ca
de c0 ad 0b ef cd ab 89
46 0a
// Reply to p
a5 01 02 03 10 20 30 40
de ad be ef 5a 3c 7e 81
78 56 34 12 0d f0 fe ca
de c0 ad 0b ef cd ab 89
46 0a

//--- all.f
common/debug_pkg.sv
src/cmd_rx.sv
src/run_ctrl.sv
dump/dump_seq.sv
dump/tx_out.sv
src/debug_top.sv
test/debug_props.sv
test/debug_tb.sv

//--- Bender.yml
package:
  name: uart_debug_unit

sources:
  - common/debug_pkg.sv
  - src/cmd_rx.sv
  - src/run_ctrl.sv
  - dump/dump_seq.sv
  - dump/tx_out.sv
  - src/debug_top.sv
  - target: test
    files:
      - test/debug_props.sv
      - test/debug_tb.sv

//--- test/debug_tb.sv
`default_nettype none

module debug_tb;

	localparam logic [31:0] SEED = 32'h2e67_8911;
	localparam int BW = debug_pkg::BYTE_W;
	localparam int GOLD_MEM = 'h10; // Memory words at 80 onward
	localparam int GOLD_CMDS = 'h14; // Command count, then (byte, enable cycles) pairs
	localparam int GOLD_EXP = 'h40; // Reply byte count, then the bytes

	logic clk;
	logic rst_i;
	logic [BW-1:0] r_data_i;
	logic rx_empty_i;
	logic tx_full_i;
	logic cpu_halt_i;
	logic [debug_pkg::DUMP_BYTES*BW-1:0] snapshot_i;
	logic [debug_pkg::WORD_W-1:0] mem_data_i;
	wire rd_o;
	wire [BW-1:0] w_data_o;
	wire wr_o;
	wire cpu_reset_o;
	wire cpu_enable_o;
	wire mem_rd_o;
	wire [debug_pkg::ADDR_W-1:0] mem_addr_o;

	logic [31:0] gold [0:255];
	int exp_count = 0;
	int tx_count = 0;
	int limit = 0;
	int cycles = 0;
	int data_errs = 0;
	int ctrl_errs = 0;
	int reset_pulses = 0;
	int strobes = 0;
	int good_cmds = 0;
	logic [BW-1:0] rx_q [$];
	logic [BW-1:0] run_cmd_q [$];
	int run_len_q [$];

	debug_top dut
	(
		.clk(clk),
		.rst_i(rst_i),
		.r_data_i(r_data_i),
		.rx_empty_i(rx_empty_i),
		.rd_o(rd_o),
		.w_data_o(w_data_o),
		.wr_o(wr_o),
		.tx_full_i(tx_full_i),
		.cpu_reset_o(cpu_reset_o),
		.cpu_enable_o(cpu_enable_o),
		.cpu_halt_i(cpu_halt_i),
		.snapshot_i(snapshot_i),
		.mem_rd_o(mem_rd_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_i(mem_data_i)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Golden words inside the window, address based fill elsewhere
	function automatic logic [31:0] mem_word(input logic [debug_pkg::ADDR_W-1:0] addr);
		int ofs;
		ofs = int'(addr) - int'(debug_pkg::MEM_BASE);
		if (ofs >= 0 && ofs < debug_pkg::MEM_WORDS)
			return gold[GOLD_MEM + ofs];
		return {4'ha, addr, 4'h5, addr};
	endfunction

	task automatic check_byte(input logic [BW-1:0] b);
		logic [BW-1:0] exp;
		assert (tx_count < exp_count)
		else
		begin
			data_errs++;
			$display("t=%0t reply byte %h written after the last expected byte", $time, b);
		end
		if (tx_count < exp_count)
		begin
			exp = gold[GOLD_EXP + 1 + tx_count][BW-1:0];
			assert (b === exp)
			else
			begin
				data_errs++;
				$display("FAILED t=%0t w_data_o (byte %0d): got %h, expected %h",
					$time, tx_count, b, exp);
			end
		end
		tx_count++;
	endtask

	////////////////////////////////////////
	// Receive FIFO model
	////////////////////////////////////////
	logic rx_busy = 1'b0;
	int rx_wait = -1;

	always @(negedge clk)
	begin
		if (rx_busy)
		begin
			if (!rd_o)
				rx_busy = 1'b0;
		end
		else if (rd_o === 1'b1 && rx_q.size() > 0)
		begin
			if (rx_wait < 0)
				rx_wait = $urandom_range(2, 0); // FIFO read latency
			if (rx_wait == 0)
			begin
				r_data_i = rx_q.pop_front();
				rx_empty_i = 1'b1; // Empty rising acknowledges the read
				rx_busy = 1'b1;
			end
			rx_wait--;
		end
		if (!rx_busy)
			rx_empty_i = (rx_q.size() == 0);
	end

	////////////////////////////////////////
	// Processor model
	////////////////////////////////////////
	logic en_prev = 1'b0;
	logic [BW-1:0] cur_cmd = '0;
	int cur_len = 0;
	int en_cycles = 0;

	always @(negedge clk)
	begin
		if (cpu_enable_o === 1'b1)
		begin
			if (!en_prev)
			begin
				assert (run_cmd_q.size() > 0)
				else
				begin
					ctrl_errs++;
					$display("t=%0t processor enabled with no step or continue pending", $time);
				end
				if (run_cmd_q.size() > 0)
				begin
					cur_cmd = run_cmd_q.pop_front();
					cur_len = run_len_q.pop_front();
				end
				en_cycles = 0;
			end
			en_cycles++;
			cpu_halt_i = (cur_cmd == debug_pkg::CMD_CONT) && (en_cycles >= cur_len);
		end
		else
		begin
			if (en_prev)
			begin
				assert (en_cycles == cur_len)
				else
				begin
					ctrl_errs++;
					$display("FAILED t=%0t cpu_enable_o cycles: got %0d, expected %0d",
						$time, en_cycles, cur_len);
				end
			end
			cpu_halt_i = 1'b0;
		end
		en_prev = (cpu_enable_o === 1'b1);
		if (!rst_i && cpu_reset_o === 1'b1)
			reset_pulses++;
	end

	// Memory model with fixed read latency
	logic [debug_pkg::ADDR_W-1:0] mem_addr_q;
	int mem_wait = 0;

	always @(negedge clk)
	begin
		if (mem_rd_o === 1'b1)
		begin
			assert (mem_addr_o == debug_pkg::MEM_BASE + (strobes % debug_pkg::MEM_WORDS))
			else
			begin
				ctrl_errs++;
				$display("FAILED t=%0t mem_addr_o: got %0d, expected %0d", $time, mem_addr_o,
					debug_pkg::MEM_BASE + (strobes % debug_pkg::MEM_WORDS));
			end
			mem_addr_q = mem_addr_o;
			mem_wait = debug_pkg::MEM_LATENCY;
			mem_data_i = 'x; // Early use shows up as a byte mismatch
			strobes++;
		end
		else if (mem_wait > 0)
		begin
			mem_wait--;
			if (mem_wait == 0)
				mem_data_i = mem_word(mem_addr_q);
		end
	end

	////////////////////////////////////////
	// Transmit FIFO model
	////////////////////////////////////////
	initial
	begin
		int d;
		forever
		begin
			@(negedge clk);
			if (wr_o === 1'b1 && !tx_full_i)
			begin
				d = $urandom_range(4, 1);
				repeat (d) @(negedge clk);
				check_byte(w_data_o);
				tx_full_i = 1'b1;
				d = $urandom_range(3, 1);
				repeat (d) @(negedge clk);
				tx_full_i = 1'b0;
			end
		end
	end

	function automatic int total_errs();
		return data_errs + ctrl_errs + dut.u_props.prop_fails;
	endfunction

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("Timeout: %0d of %0d reply bytes seen after %0d cycles",
				tx_count, exp_count, cycles);
			$display("Errors: %0d data, %0d control, %0d assertion",
				data_errs, ctrl_errs, dut.u_props.prop_fails);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	initial
	begin
		int n_cmds;
		int sum_len;
		logic [BW-1:0] c;
		int len;
		void'($urandom(SEED));
		$readmemh("test/debug_golden.txt", gold);
		rst_i = 1'b1;
		r_data_i = '0;
		rx_empty_i = 1'b1;
		tx_full_i = 1'b0;
		cpu_halt_i = 1'b0;
		mem_data_i = '0;
		for (int i = 0; i < debug_pkg::DUMP_BYTES; i++)
			snapshot_i[i*BW +: BW] = gold[i][BW-1:0];
		n_cmds = gold[GOLD_CMDS];
		exp_count = gold[GOLD_EXP];
		sum_len = 0;
		for (int i = 0; i < n_cmds; i++)
			if (gold[GOLD_CMDS + 1 + 2*i][BW-1:0] == debug_pkg::CMD_CONT)
				sum_len += gold[GOLD_CMDS + 2 + 2*i];
		limit = exp_count * 16 + sum_len + 200;

		repeat (4) @(negedge clk);
		assert (!rd_o && !wr_o && !cpu_enable_o && !mem_rd_o)
		else
		begin
			ctrl_errs++;
			$display("t=%0t a FIFO or processor control output is high in reset", $time);
		end
		rst_i = 1'b0;
		@(negedge clk);
		assert (cpu_reset_o === 1'b1)
		else
		begin
			ctrl_errs++;
			$display("FAILED t=%0t cpu_reset_o: got %b, expected 1", $time, cpu_reset_o);
		end

		// Whole command list queued back to back
		for (int i = 0; i < n_cmds; i++)
		begin
			c = gold[GOLD_CMDS + 1 + 2*i][BW-1:0];
			len = gold[GOLD_CMDS + 2 + 2*i];
			rx_q.push_back(c);
			if (c == debug_pkg::CMD_STEP || c == debug_pkg::CMD_CONT)
			begin
				run_cmd_q.push_back(c);
				run_len_q.push_back(len);
				good_cmds++;
			end
		end

		while (tx_count < exp_count)
			@(negedge clk);
		repeat (50) @(negedge clk); // Catch stray bytes

		assert (reset_pulses == 1)
		else
		begin
			ctrl_errs++;
			$display("FAILED t=%0t cpu_reset_o pulses: got %0d, expected 1", $time, reset_pulses);
		end
		assert (strobes == good_cmds * debug_pkg::MEM_WORDS)
		else
		begin
			ctrl_errs++;
			$display("FAILED t=%0t mem_rd_o strobes: got %0d, expected %0d", $time, strobes,
				good_cmds * debug_pkg::MEM_WORDS);
		end
		assert (rx_q.size() == 0 && run_cmd_q.size() == 0)
		else
		begin
			ctrl_errs++;
			$display("t=%0t some commands were never read or never run", $time);
		end

		$display("Errors: %0d data, %0d control, %0d assertion",
			data_errs, ctrl_errs, dut.u_props.prop_fails);
		if (total_errs() == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/debug_props.sv
`default_nettype none

module debug_props
(
	input wire clk,
	input wire rst_i,
	input wire rd_o,
	input wire rx_empty_i,
	input wire [debug_pkg::BYTE_W-1:0] w_data_o,
	input wire wr_o,
	input wire tx_full_i,
	input wire cpu_reset_o,
	input wire cpu_enable_o,
	input wire mem_rd_o
);

	int prop_fails = 0;

	////////////////////////////////////////
	// FIFO handshakes
	////////////////////////////////////////
	write_held: assert property (@(posedge clk) disable iff (rst_i)
		wr_o && !tx_full_i |=> wr_o && $stable(w_data_o))
	else
	begin
		prop_fails++;
		$error("wr_o fell or w_data_o changed before tx_full_i acknowledged");
	end

	read_held: assert property (@(posedge clk) disable iff (rst_i)
		rd_o && !rx_empty_i |=> rd_o)
	else
	begin
		prop_fails++;
		$error("rd_o fell before rx_empty_i acknowledged the read");
	end

	// Control outputs quiet right after reset
	reset_quiet: assert property (@(posedge clk)
		rst_i |=> !rd_o && !wr_o && !cpu_enable_o && !mem_rd_o)
	else
	begin
		prop_fails++;
		$error("control output high right after reset");
	end

	mem_strobe: assert property (@(posedge clk) disable iff (rst_i)
		mem_rd_o |=> !mem_rd_o)
	else
	begin
		prop_fails++;
		$error("mem_rd_o high for two cycles in a row");
	end

	cpu_reset_pulse: assert property (@(posedge clk) disable iff (rst_i)
		cpu_reset_o |=> !cpu_reset_o)
	else
	begin
		prop_fails++;
		$error("cpu_reset_o longer than one cycle");
	end

endmodule

bind debug_top debug_props u_props
(
	.clk(clk),
	.rst_i(rst_i),
	.rd_o(rd_o),
	.rx_empty_i(rx_empty_i),
	.w_data_o(w_data_o),
	.wr_o(wr_o),
	.tx_full_i(tx_full_i),
	.cpu_reset_o(cpu_reset_o),
	.cpu_enable_o(cpu_enable_o),
	.mem_rd_o(mem_rd_o)
);

`default_nettype wire

//--- src/debug_top.sv
`default_nettype none

module debug_top
(
	input wire clk,
	input wire rst_i,

	// Receive FIFO
	input wire [debug_pkg::BYTE_W-1:0] r_data_i,
	input wire rx_empty_i,
	output logic rd_o,

	// Transmit FIFO
	output logic [debug_pkg::BYTE_W-1:0] w_data_o,
	output logic wr_o,
	input wire tx_full_i,

	// Processor
	output logic cpu_reset_o,
	output logic cpu_enable_o,
	input wire cpu_halt_i,
	input wire [debug_pkg::DUMP_BYTES*debug_pkg::BYTE_W-1:0] snapshot_i,

	// Data memory read port
	output logic mem_rd_o,
	output logic [debug_pkg::ADDR_W-1:0] mem_addr_o,
	input wire [debug_pkg::WORD_W-1:0] mem_data_i
);

	logic cmd_valid;
	debug_pkg::cmd_e cmd;
	logic cmd_take;
	logic dump_start;
	logic err_start;
	logic dump_done;
	logic byte_valid;
	logic [debug_pkg::BYTE_W-1:0] byte_data;
	logic byte_sent;

	cmd_rx u_cmd_rx
	(
		.clk(clk),
		.rst_i(rst_i),
		.r_data_i(r_data_i),
		.rx_empty_i(rx_empty_i),
		.cmd_take_i(cmd_take),
		.rd_o(rd_o),
		.cmd_valid_o(cmd_valid),
		.cmd_o(cmd)
	);

	run_ctrl u_run_ctrl
	(
		.clk(clk),
		.rst_i(rst_i),
		.cmd_valid_i(cmd_valid),
		.cmd_i(cmd),
		.cpu_halt_i(cpu_halt_i),
		.dump_done_i(dump_done),
		.cmd_take_o(cmd_take),
		.cpu_reset_o(cpu_reset_o),
		.cpu_enable_o(cpu_enable_o),
		.dump_start_o(dump_start),
		.err_start_o(err_start)
	);

	dump_seq u_dump_seq
	(
		.clk(clk),
		.rst_i(rst_i),
		.dump_start_i(dump_start),
		.err_start_i(err_start),
		.snapshot_i(snapshot_i),
		.mem_data_i(mem_data_i),
		.byte_sent_i(byte_sent),
		.mem_rd_o(mem_rd_o),
		.mem_addr_o(mem_addr_o),
		.byte_valid_o(byte_valid),
		.byte_data_o(byte_data),
		.dump_done_o(dump_done)
	);

	tx_out u_tx_out
	(
		.clk(clk),
		.rst_i(rst_i),
		.byte_valid_i(byte_valid),
		.byte_data_i(byte_data),
		.tx_full_i(tx_full_i),
		.w_data_o(w_data_o),
		.wr_o(wr_o),
		.byte_sent_o(byte_sent)
	);

endmodule

`default_nettype wire

//--- dump/tx_out.sv
`default_nettype none

module tx_out
(
	input wire clk,
	input wire rst_i,
	input wire byte_valid_i,
	input wire [debug_pkg::BYTE_W-1:0] byte_data_i,
	input wire tx_full_i,
	output logic [debug_pkg::BYTE_W-1:0] w_data_o,
	output logic wr_o,
	output logic byte_sent_o
);

	typedef enum logic [1:0] {TX_IDLE, TX_PEND, TX_WRITE} state_t;

	state_t state_q;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= TX_IDLE;
			wr_o <= 1'b0;
			byte_sent_o <= 1'b0;
		end
		else
		begin
			byte_sent_o <= 1'b0;
			case (state_q)
				TX_IDLE:
				begin
					if (byte_valid_i)
						state_q <= TX_PEND;
				end
				TX_PEND:
				begin
					if (!tx_full_i) // FIFO ready for the next byte
					begin
						wr_o <= 1'b1;
						state_q <= TX_WRITE;
					end
				end
				default:
				begin
					// Full flag doubles as the write acknowledge
					if (tx_full_i)
					begin
						wr_o <= 1'b0;
						byte_sent_o <= 1'b1;
						state_q <= TX_IDLE;
					end
				end
			endcase
		end
	end

	// Data held from accept until the acknowledge
	always_ff @(posedge clk)
	begin
		if (state_q == TX_IDLE && byte_valid_i)
			w_data_o <= byte_data_i;
	end

endmodule

`default_nettype wire

//--- dump/dump_seq.sv
`default_nettype none

module dump_seq
(
	input wire clk,
	input wire rst_i,
	input wire dump_start_i,
	input wire err_start_i,
	input wire [debug_pkg::DUMP_BYTES*debug_pkg::BYTE_W-1:0] snapshot_i,
	input wire [debug_pkg::WORD_W-1:0] mem_data_i,
	input wire byte_sent_i,
	output logic mem_rd_o,
	output logic [debug_pkg::ADDR_W-1:0] mem_addr_o,
	output logic byte_valid_o,
	output logic [debug_pkg::BYTE_W-1:0] byte_data_o,
	output logic dump_done_o
);

	typedef enum logic [2:0] {DS_IDLE, DS_SEND, DS_WAIT, DS_MEM_RD, DS_MEM_WAIT} state_t;

	state_t state_q;
	debug_pkg::src_e src_q;
	logic [debug_pkg::DUMP_BYTES*debug_pkg::BYTE_W-1:0] snap_q;
	logic [$clog2(debug_pkg::DUMP_BYTES)-1:0] idx_q;
	logic [$clog2(debug_pkg::MEM_WORDS)-1:0] word_q;
	logic [$clog2(debug_pkg::MEM_LATENCY)-1:0] wait_q;
	logic err_q;
	logic [$clog2(debug_pkg::BYTES_PER_WORD)-1:0] lane;
	logic [debug_pkg::BYTE_W-1:0] cur_byte;

	assign mem_rd_o = (state_q == DS_MEM_RD);
	assign mem_addr_o = debug_pkg::MEM_BASE + word_q;
	assign lane = idx_q[$clog2(debug_pkg::BYTES_PER_WORD)-1:0];

	////////////////////////////////////////
	// Byte select
	////////////////////////////////////////
	always_comb
	begin
		case (src_q)
			debug_pkg::SRC_SNAP:
				cur_byte = snap_q[idx_q*debug_pkg::BYTE_W +: debug_pkg::BYTE_W];
			debug_pkg::SRC_MEM:
				cur_byte = mem_data_i[lane*debug_pkg::BYTE_W +: debug_pkg::BYTE_W];
			default:
			begin
				if (idx_q == '0)
					cur_byte = err_q ? debug_pkg::CH_ERR : debug_pkg::CH_FIN;
				else
					cur_byte = debug_pkg::CH_NL;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= DS_IDLE;
			word_q <= '0;
			byte_valid_o <= 1'b0;
			dump_done_o <= 1'b0;
		end
		else
		begin
			byte_valid_o <= 1'b0;
			dump_done_o <= 1'b0;
			case (state_q)
				DS_IDLE:
				begin
					idx_q <= '0;
					word_q <= '0;
					if (dump_start_i)
					begin
						snap_q <= snapshot_i; // Freeze processor state
						src_q <= debug_pkg::SRC_SNAP;
						err_q <= 1'b0;
						state_q <= DS_SEND;
					end
					else if (err_start_i)
					begin
						src_q <= debug_pkg::SRC_TRL;
						err_q <= 1'b1;
						state_q <= DS_SEND;
					end
				end
				DS_SEND:
				begin
					byte_valid_o <= 1'b1;
					byte_data_o <= cur_byte;
					state_q <= DS_WAIT;
				end
				DS_WAIT:
				begin
					if (byte_sent_i)
					begin
						idx_q <= idx_q + 1'b1;
						state_q <= DS_SEND;
						case (src_q)
							debug_pkg::SRC_SNAP:
							begin
								if (idx_q == debug_pkg::DUMP_BYTES - 1)
								begin
									src_q <= debug_pkg::SRC_MEM;
									state_q <= DS_MEM_RD;
								end
							end
							debug_pkg::SRC_MEM:
							begin
								if (idx_q == debug_pkg::BYTES_PER_WORD - 1)
								begin
									idx_q <= '0;
									if (word_q == debug_pkg::MEM_WORDS - 1)
										src_q <= debug_pkg::SRC_TRL;
									else
									begin
										word_q <= word_q + 1'b1;
										state_q <= DS_MEM_RD;
									end
								end
							end
							default:
							begin
								if (idx_q != '0)
								begin
									dump_done_o <= 1'b1; // Newline acknowledged
									state_q <= DS_IDLE;
								end
							end
						endcase
					end
				end
				DS_MEM_RD:
				begin
					idx_q <= '0;
					wait_q <= '0;
					state_q <= DS_MEM_WAIT;
				end
				default:
				begin
					wait_q <= wait_q + 1'b1;
					if (wait_q == debug_pkg::MEM_LATENCY - 1)
						state_q <= DS_SEND;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/run_ctrl.sv
`default_nettype none

module run_ctrl
(
	input wire clk,
	input wire rst_i,
	input wire cmd_valid_i,
	input var debug_pkg::cmd_e cmd_i,
	input wire cpu_halt_i,
	input wire dump_done_i,
	output logic cmd_take_o,
	output logic cpu_reset_o,
	output logic cpu_enable_o,
	output logic dump_start_o,
	output logic err_start_o
);

	typedef enum logic [2:0] {RC_BOOT, RC_IDLE, RC_STEP, RC_CONT, RC_BUSY} state_t;

	state_t state_q;

	assign cmd_take_o = (state_q == RC_IDLE) && cmd_valid_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			state_q <= RC_BOOT;
			cpu_reset_o <= 1'b0;
			cpu_enable_o <= 1'b0;
			dump_start_o <= 1'b0;
			err_start_o <= 1'b0;
		end
		else
		begin
			cpu_reset_o <= (state_q == RC_BOOT); // Single pulse out of reset
			dump_start_o <= 1'b0;
			err_start_o <= 1'b0;
			case (state_q)
				RC_BOOT:
					state_q <= RC_IDLE;
				RC_IDLE:
				begin
					if (cmd_valid_i)
					begin
						case (cmd_i)
							debug_pkg::DO_STEP:
							begin
								cpu_enable_o <= 1'b1;
								state_q <= RC_STEP;
							end
							debug_pkg::DO_CONT:
							begin
								cpu_enable_o <= 1'b1;
								state_q <= RC_CONT;
							end
							default:
							begin
								err_start_o <= 1'b1;
								state_q <= RC_BUSY;
							end
						endcase
					end
				end
				RC_STEP:
				begin
					cpu_enable_o <= 1'b0;
					dump_start_o <= 1'b1;
					state_q <= RC_BUSY;
				end
				RC_CONT:
				begin
					// Run until write-back reports halt
					if (cpu_halt_i)
					begin
						cpu_enable_o <= 1'b0;
						dump_start_o <= 1'b1;
						state_q <= RC_BUSY;
					end
				end
				default:
				begin
					if (dump_done_i)
						state_q <= RC_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/cmd_rx.sv
`default_nettype none

module cmd_rx
(
	input wire clk,
	input wire rst_i,
	input wire [debug_pkg::BYTE_W-1:0] r_data_i,
	input wire rx_empty_i,
	input wire cmd_take_i,
	output logic rd_o,
	output logic cmd_valid_o,
	output debug_pkg::cmd_e cmd_o
);

	logic sample;

	// FIFO has delivered the byte once empty rises again
	assign sample = rd_o && rx_empty_i;

	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			rd_o <= 1'b0;
			cmd_valid_o <= 1'b0;
		end
		else if (rd_o)
		begin
			if (rx_empty_i)
			begin
				rd_o <= 1'b0;
				cmd_valid_o <= 1'b1;
			end
		end
		else if (cmd_valid_o)
		begin
			if (cmd_take_i)
				cmd_valid_o <= 1'b0; // Slot free again
		end
		else if (!rx_empty_i)
		begin
			rd_o <= 1'b1;
		end
	end

	////////////////////////////////////////
	// Command decode
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (sample)
		begin
			case (r_data_i)
				debug_pkg::CMD_STEP:
					cmd_o <= debug_pkg::DO_STEP;
				debug_pkg::CMD_CONT:
					cmd_o <= debug_pkg::DO_CONT;
				default:
					cmd_o <= debug_pkg::DO_BAD;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- common/debug_pkg.sv
`default_nettype none

package debug_pkg;

	////////////////////////////////////////
	// Widths and dump sizes
	////////////////////////////////////////
	localparam int BYTE_W         = 8;
	localparam int WORD_W         = 32;
	localparam int BYTES_PER_WORD = 4;
	localparam int DUMP_BYTES     = 16; // Snapshot length
	localparam int MEM_WORDS      = 4;
	localparam int ADDR_W         = 12;
	localparam int MEM_LATENCY    = 4;  // Strobe to valid data

	localparam logic [ADDR_W-1:0] MEM_BASE = 12'd80;

	////////////////////////////////////////
	// Command and reply characters
	////////////////////////////////////////
	localparam logic [BYTE_W-1:0] CMD_STEP = 8'h70; // p
	localparam logic [BYTE_W-1:0] CMD_CONT = 8'h63; // c
	localparam logic [BYTE_W-1:0] CH_ERR   = 8'h45; // E
	localparam logic [BYTE_W-1:0] CH_FIN   = 8'h46; // F
	localparam logic [BYTE_W-1:0] CH_NL    = 8'h0a;

	// Decoded command
	typedef enum logic [1:0] {DO_STEP, DO_CONT, DO_BAD} cmd_e;

	// Byte source while dumping
	typedef enum logic [1:0] {SRC_SNAP, SRC_MEM, SRC_TRL} src_e;

endpackage

`default_nettype wire
